/* compile.f */
+incdir+dv
source/mul_pkg.sv
source/mul_ctl.sv
source/mul_array.sv
source/clmul_unit.sv
source/perm_unit.sv
source/crc_unit.sv
source/exu_mul_top.sv
dv/tb_exu_mul_top.sv

/* Makefile */
# Verilator build, run, lint and clean for the multiply stage

VERILATOR   ?= verilator
TOP         ?= tb_exu_mul_top
RTL_TOP     ?= exu_mul_top
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_STRING ?= Test OK
VFLAGS      ?= --binary --timing -Wno-fatal
LINT_FLAGS  ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_STRING)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		source/mul_pkg.sv source/mul_ctl.sv source/mul_array.sv \
		source/clmul_unit.sv source/perm_unit.sv source/crc_unit.sv \
		source/exu_mul_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mul_model.svh */
// Reference model functions giving the expected result of every multiply stage operation
`ifndef MUL_MODEL_SVH
`define MUL_MODEL_SVH

// Shift-and-XOR product with bit 63 always zero
function automatic logic [63:0] clmul_product(logic [31:0] a, logic [31:0] b);
   logic [63:0] acc;
   acc = '0;
   for (int i = 0; i < 32; i++)
   begin
      if (b[i])
      begin
         acc = acc ^ ({32'b0, a} << i);
      end
   end
   return acc;
endfunction

function automatic logic [31:0] perm_stages(logic [31:0] a, logic [4:0] shamt, bit orc);
   logic [31:0] x;
   logic [31:0] sw;
   logic [31:0] masks [5];
   masks = '{32'h5555_5555, 32'h3333_3333, 32'h0F0F_0F0F, 32'h00FF_00FF, 32'h0000_FFFF};
   x = a;
   for (int s = 0; s < 5; s++)
   begin
      if (shamt[s])
      begin
         sw = ((x & masks[s]) << (1 << s)) | ((x & ~masks[s]) >> (1 << s));
         x  = orc ? (x | sw) : sw;
      end
   end
   return x;
endfunction

function automatic logic [31:0] crc_shift(logic [31:0] a, logic [31:0] poly, int nbits);
   logic [31:0] c;
   c = a;
   for (int i = 0; i < nbits; i++)
   begin
      c = c[0] ? ((c >> 1) ^ poly) : (c >> 1);
   end
   return c;
endfunction

function automatic logic [31:0] expected_result(mul_pkg::mul_op_e op, logic [31:0] a,
                                                logic [31:0] b);
   longint      p;
   logic [63:0] cl;
   cl = clmul_product(a, b);
   case (op)
      mul_pkg::OP_MUL:
      begin
         p = longint'($signed(a)) * longint'($signed(b));
         return p[31:0];
      end
      mul_pkg::OP_MULH:
      begin
         p = longint'($signed(a)) * longint'($signed(b));
         return p[63:32];
      end
      mul_pkg::OP_MULHSU:
      begin
         p = longint'($signed(a)) * longint'({32'b0, b});
         return p[63:32];
      end
      mul_pkg::OP_MULHU:
      begin
         p = longint'({32'b0, a}) * longint'({32'b0, b});
         return p[63:32];
      end
      mul_pkg::OP_CLMUL:   return cl[31:0];
      mul_pkg::OP_CLMULH:  return cl[63:32];
      mul_pkg::OP_CLMULR:  return cl[62:31];
      mul_pkg::OP_GREV:    return perm_stages(a, b[4:0], 1'b0);
      mul_pkg::OP_GORC:    return perm_stages(a, b[4:0], 1'b1);
      mul_pkg::OP_CRC32_B:  return crc_shift(a, 32'hEDB8_8320, 8);
      mul_pkg::OP_CRC32_H:  return crc_shift(a, 32'hEDB8_8320, 16);
      mul_pkg::OP_CRC32_W:  return crc_shift(a, 32'hEDB8_8320, 32);
      mul_pkg::OP_CRC32C_B: return crc_shift(a, 32'h82F6_3B78, 8);
      mul_pkg::OP_CRC32C_H: return crc_shift(a, 32'h82F6_3B78, 16);
      mul_pkg::OP_CRC32C_W: return crc_shift(a, 32'h82F6_3B78, 32);
      default:             return '0;
   endcase
endfunction

`endif

/* dv/tb_exu_mul_top.sv */
// Testbench for the multiply stage with random stimulus checked against a reference model
`timescale 1ns/1ps

module tb_exu_mul_top;

   `include "mul_model.svh"

   localparam int SEED       = 30992;
   localparam int N_RANDOM   = 3000;
   localparam int MAX_CYCLES = 20000;

   logic                     clk;
   logic                     arst_n;
   mul_pkg::mul_pkt_t        mul_pkt;
   logic [mul_pkg::XLEN-1:0] rs1;
   logic [mul_pkg::XLEN-1:0] rs2;
   logic [mul_pkg::XLEN-1:0] result;

   // Scoreboard entry for the last valid packet
   logic [31:0] exp_result;
   string       exp_desc;
   bit          done;

   logic [31:0] edge_vals [6];

   exu_mul_top i_dut (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .mul_pkt_i (mul_pkt),
      .rs1_i     (rs1),
      .rs2_i     (rs2),
      .result_o  (result)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #50 clk = ~clk;

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERROR at %0t: %s, got %h, expected %h", $time, what, got, exp);
         $display("Test FAILED");
         $fatal(1, "Result mismatch");
      end
   endtask

   // Check the previous result on the falling edge before driving new inputs
   task automatic drive_cycle(input bit valid, input mul_pkg::mul_op_e op,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] exp);
      @(negedge clk);
      check_value(exp_desc, result, exp_result);
      mul_pkt.valid = valid;
      mul_pkt.op    = op;
      rs1           = a;
      rs2           = b;
      if (valid)
      begin
         exp_result = exp;
         exp_desc   = $sformatf("%s a=%h b=%h", op.name(), a, b);
      end
   endtask

   task automatic run_op(input mul_pkg::mul_op_e op, input logic [31:0] a,
                         input logic [31:0] b);
      drive_cycle(1'b1, op, a, b, expected_result(op, a, b));
   endtask

   task automatic idle_cycle();
      mul_pkg::mul_op_e op;
      op = mul_pkg::mul_op_e'($urandom_range(14, 0));
      drive_cycle(1'b0, op, $urandom, $urandom, 32'h0);
   endtask

   function automatic mul_pkg::mul_op_e random_op();
      return mul_pkg::mul_op_e'($urandom_range(14, 0));
   endfunction

   // Watchdog bounding the whole run
   initial
   begin
      for (int c = 0; c < MAX_CYCLES && !done; c++)
      begin
         @(posedge clk);
      end
      if (!done)
      begin
         $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
         $display("Test FAILED");
         $fatal(1, "Watchdog timeout");
      end
   end

   initial
   begin
      logic [31:0] b;
      arst_n        = 1'b0;
      mul_pkt.valid = 1'b0;
      mul_pkt.op    = mul_pkg::OP_MUL;
      rs1           = '0;
      rs2           = '0;
      exp_result    = '0;
      exp_desc      = "reset value";
      done          = 1'b0;
      edge_vals     = '{32'h0000_0000, 32'h0000_0001, 32'h7FFF_FFFF,
                        32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_FFFF};
      void'($urandom(SEED));

      for (int i = 0; i < 3; i++)
      begin
         @(posedge clk);
      end
      @(negedge clk);
      arst_n = 1'b1;

      // Result stays zero while idle after reset
      for (int i = 0; i < 4; i++)
      begin
         idle_cycle();
      end

      // Integer multiplies at the operand extremes
      for (int op = 0; op < 4; op++)
      begin
         for (int i = 0; i < 6; i++)
         begin
            for (int j = 0; j < 6; j++)
            begin
               run_op(mul_pkg::mul_op_e'(op), edge_vals[i], edge_vals[j]);
            end
         end
      end

      // Carry-less multiplies of all ones and of random operands
      run_op(mul_pkg::OP_CLMUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      run_op(mul_pkg::OP_CLMULH, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      run_op(mul_pkg::OP_CLMULR, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
      for (int i = 0; i < 50; i++)
      begin
         run_op(mul_pkg::OP_CLMUL, $urandom, $urandom);
         run_op(mul_pkg::OP_CLMULH, $urandom, $urandom);
         run_op(mul_pkg::OP_CLMULR, $urandom, $urandom);
      end

      // Every shift amount for both permutations
      for (int s = 0; s < 32; s++)
      begin
         b      = $urandom;
         b[4:0] = s[4:0];
         run_op(mul_pkg::OP_GREV, $urandom, b);
         run_op(mul_pkg::OP_GORC, $urandom, b);
      end

      // Known CRC byte steps
      check_value("model CRC32 byte reference",
                  expected_result(mul_pkg::OP_CRC32_B, 32'hFFFF_FF9E, 32'h0), 32'h1748_41BC);
      check_value("model CRC32C byte reference",
                  expected_result(mul_pkg::OP_CRC32C_B, 32'hFFFF_FF9E, 32'h0), 32'h3E2F_BCCF);
      drive_cycle(1'b1, mul_pkg::OP_CRC32_B, 32'hFFFF_FF9E, $urandom, 32'h1748_41BC);
      drive_cycle(1'b1, mul_pkg::OP_CRC32C_B, 32'hFFFF_FF9E, $urandom, 32'h3E2F_BCCF);
      for (int op = 9; op < 15; op++)
      begin
         for (int i = 0; i < 20; i++)
         begin
            run_op(mul_pkg::mul_op_e'(op), $urandom, $urandom);
         end
      end

      // Mixed traffic with idle cycles in between
      for (int i = 0; i < N_RANDOM; i++)
      begin
         if ($urandom_range(3, 0) == 0)
         begin
            idle_cycle();
         end
         else
         begin
            run_op(random_op(), $urandom, $urandom);
         end
      end

      // Last result and a few held cycles
      for (int i = 0; i < 3; i++)
      begin
         idle_cycle();
      end
      @(negedge clk);
      check_value(exp_desc, result, exp_result);

      done = 1'b1;
      $display("Test OK");
      $finish;
   end

endmodule

/* source/exu_mul_top.sv */
// Multiply stage top level joining control, multiplier array and bit-manipulation units
`timescale 1ns/1ps

module exu_mul_top #(
   parameter bit EN_CLMUL = 1'b1,
   parameter bit EN_PERM  = 1'b1,
   parameter bit EN_CRC   = 1'b1
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  mul_pkg::mul_pkt_t        mul_pkt_i,
   input  logic [mul_pkg::XLEN-1:0] rs1_i,
   input  logic [mul_pkg::XLEN-1:0] rs2_i,
   output logic [mul_pkg::XLEN-1:0] result_o
);

   mul_pkg::mul_dec_t           mul_dec;
   mul_pkg::crc_cfg_t           crc_cfg;
   logic                        or_combine;
   logic [mul_pkg::PROD_W-1:0]  prod;
   logic [mul_pkg::CLMUL_W-1:0] clmul;
   logic [mul_pkg::XLEN-1:0]    perm;
   logic [mul_pkg::XLEN-1:0]    crc;

   mul_ctl #(
      .EN_CLMUL (EN_CLMUL),
      .EN_PERM  (EN_PERM),
      .EN_CRC   (EN_CRC)
   ) i_mul_ctl (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .mul_pkt_i    (mul_pkt_i),
      .mul_dec_o    (mul_dec),
      .or_combine_o (or_combine),
      .crc_cfg_o    (crc_cfg),
      .prod_i       (prod),
      .clmul_i      (clmul),
      .perm_i       (perm),
      .crc_i        (crc),
      .result_o     (result_o)
   );

   mul_array i_mul_array (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .rs1_i     (rs1_i),
      .rs2_i     (rs2_i),
      .mul_dec_i (mul_dec),
      .prod_o    (prod)
   );

   // Bit-manipulation units work on the raw operands
   clmul_unit i_clmul_unit (
      .rs1_i   (rs1_i),
      .rs2_i   (rs2_i),
      .clmul_o (clmul)
   );

   perm_unit i_perm_unit (
      .rs1_i        (rs1_i),
      .shamt_i      (rs2_i[4:0]),
      .or_combine_i (or_combine),
      .perm_o       (perm)
   );

   crc_unit i_crc_unit (
      .rs1_i     (rs1_i),
      .crc_cfg_i (crc_cfg),
      .crc_o     (crc)
   );

endmodule

/* source/crc_unit.sv */
// Reflected CRC32 or CRC32C step over a byte, halfword or word of operand A
`timescale 1ns/1ps

module crc_unit (
   input  logic [mul_pkg::XLEN-1:0] rs1_i,
   input  mul_pkg::crc_cfg_t        crc_cfg_i,
   output logic [mul_pkg::XLEN-1:0] crc_o
);

   logic [mul_pkg::XLEN-1:0] poly;
   logic [5:0]               n_steps;
   logic [mul_pkg::XLEN-1:0] crc;

   assign poly = crc_cfg_i.castagnoli ? mul_pkg::CRC32C_POLY_REV : mul_pkg::CRC32_POLY_REV;

   always_comb
   begin
      case (crc_cfg_i.width)
         mul_pkg::CRC_BYTE:
            n_steps = 6'd8;
         mul_pkg::CRC_HALF:
            n_steps = 6'd16;
         default:
            n_steps = 6'd32;
      endcase
   end

   // One LFSR shift per input bit starting at the LSB
   always_comb
   begin
      crc = rs1_i;
      for (int i = 0; i < mul_pkg::XLEN; i++)
      begin
         if (i < n_steps)
         begin
            crc = (crc >> 1) ^ (poly & {mul_pkg::XLEN{crc[0]}});
         end
      end
   end

   assign crc_o = crc;

endmodule

/* source/perm_unit.sv */
// Generalized reverse and or-combine of operand A in five butterfly stages
`timescale 1ns/1ps

module perm_unit (
   input  logic [mul_pkg::XLEN-1:0] rs1_i,
   input  logic [4:0]               shamt_i,
   input  logic                     or_combine_i,
   output logic [mul_pkg::XLEN-1:0] perm_o
);

   localparam int N_STAGES = 5;

   // Lower half of each group indexed by stage
   localparam logic [N_STAGES-1:0][mul_pkg::XLEN-1:0] LO_MASK = {
      32'h0000_FFFF,
      32'h00FF_00FF,
      32'h0F0F_0F0F,
      32'h3333_3333,
      32'h5555_5555
   };

   logic [N_STAGES:0][mul_pkg::XLEN-1:0] stage;

   assign stage[0] = rs1_i;

   for (genvar g = 0; g < N_STAGES; g++)
   begin : g_stage
      logic [mul_pkg::XLEN-1:0] swapped;
      logic [mul_pkg::XLEN-1:0] combined;

      // Swap neighbouring groups of 2**g bits
      assign swapped = ((stage[g] & LO_MASK[g]) << (1 << g))
                     | ((stage[g] & ~LO_MASK[g]) >> (1 << g));

      // GORC keeps the original bits as well
      assign combined = or_combine_i ? (stage[g] | swapped) : swapped;

      assign stage[g+1] = shamt_i[g] ? combined : stage[g];
   end

   assign perm_o = stage[N_STAGES];

endmodule

/* source/clmul_unit.sv */
// Carry-less multiplier producing the full 63-bit XOR product of two words
`timescale 1ns/1ps

module clmul_unit (
   input  logic [mul_pkg::XLEN-1:0]    rs1_i,
   input  logic [mul_pkg::XLEN-1:0]    rs2_i,
   output logic [mul_pkg::CLMUL_W-1:0] clmul_o
);

   localparam int PAD_W = mul_pkg::CLMUL_W - mul_pkg::XLEN;

   logic [mul_pkg::CLMUL_W-1:0] rs1_wide;
   logic [mul_pkg::CLMUL_W-1:0] acc;

   assign rs1_wide = {{PAD_W{1'b0}}, rs1_i};

   // Partial products are XORed with no carries between columns
   always_comb
   begin
      acc = '0;
      for (int i = 0; i < mul_pkg::XLEN; i++)
      begin
         if (rs2_i[i])
         begin
            acc = acc ^ (rs1_wide << i);
         end
      end
   end

   assign clmul_o = acc;

endmodule

/* source/mul_array.sv */
// Multiplier array registering sign-extended operands and forming their signed product
`timescale 1ns/1ps

module mul_array (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic [mul_pkg::XLEN-1:0]   rs1_i,
   input  logic [mul_pkg::XLEN-1:0]   rs2_i,
   input  mul_pkg::mul_dec_t          mul_dec_i,
   output logic [mul_pkg::PROD_W-1:0] prod_o
);

   logic signed [mul_pkg::XLEN:0]     rs1_ext;
   logic signed [mul_pkg::XLEN:0]     rs2_ext;
   logic signed [mul_pkg::XLEN:0]     rs1_q;
   logic signed [mul_pkg::XLEN:0]     rs2_q;
   logic signed [mul_pkg::PROD_W-1:0] prod_s;

   // Extra top bit carries the sign only for a signed operand
   assign rs1_ext = {mul_dec_i.rs1_sign & rs1_i[mul_pkg::XLEN-1], rs1_i};
   assign rs2_ext = {mul_dec_i.rs2_sign & rs2_i[mul_pkg::XLEN-1], rs2_i};

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rs1_q <= '0;
         rs2_q <= '0;
      end
      else if (mul_dec_i.enable)
      begin
         rs1_q <= rs1_ext;
         rs2_q <= rs2_ext;
      end
   end

   // 33x33 signed multiply covers all four signedness cases
   assign prod_s = rs1_q * rs2_q;
   assign prod_o = prod_s;

endmodule

/* source/mul_ctl.sv */
// Multiply stage control: operation decode, stage registers and output word select
`timescale 1ns/1ps

module mul_ctl #(
   parameter bit EN_CLMUL = 1'b1,
   parameter bit EN_PERM  = 1'b1,
   parameter bit EN_CRC   = 1'b1
) (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  mul_pkg::mul_pkt_t           mul_pkt_i,
   output mul_pkg::mul_dec_t           mul_dec_o,
   output logic                        or_combine_o,
   output mul_pkg::crc_cfg_t           crc_cfg_o,
   input  logic [mul_pkg::PROD_W-1:0]  prod_i,
   input  logic [mul_pkg::CLMUL_W-1:0] clmul_i,
   input  logic [mul_pkg::XLEN-1:0]    perm_i,
   input  logic [mul_pkg::XLEN-1:0]    crc_i,
   output logic [mul_pkg::XLEN-1:0]    result_o
);

   logic                     rs1_sign;
   logic                     rs2_sign;
   logic                     low_d;
   logic                     is_clmul;
   logic                     is_clmulh;
   logic                     is_clmulr;
   logic                     is_perm;
   logic                     is_crc;
   logic                     sel_clmul;
   logic                     sel_clmulh;
   logic                     sel_clmulr;
   logic                     sel_perm;
   logic                     sel_crc;
   logic                     bit_sel_d;
   logic [mul_pkg::XLEN-1:0] bit_d;
   logic                     low_q;
   logic                     bit_sel_q;
   logic [mul_pkg::XLEN-1:0] bit_q;

   always_comb
   begin
      rs1_sign  = 1'b0;
      rs2_sign  = 1'b0;
      low_d     = 1'b0;
      is_clmul  = 1'b0;
      is_clmulh = 1'b0;
      is_clmulr = 1'b0;
      is_perm   = 1'b0;
      is_crc    = 1'b0;
      crc_cfg_o.width = mul_pkg::CRC_BYTE;
      case (mul_pkt_i.op)
         mul_pkg::OP_MUL:
            low_d = 1'b1;
         mul_pkg::OP_MULH:
         begin
            rs1_sign = 1'b1;
            rs2_sign = 1'b1;
         end
         mul_pkg::OP_MULHSU:
            rs1_sign = 1'b1;
         mul_pkg::OP_CLMUL:
            is_clmul = 1'b1;
         mul_pkg::OP_CLMULH:
            is_clmulh = 1'b1;
         mul_pkg::OP_CLMULR:
            is_clmulr = 1'b1;
         mul_pkg::OP_GREV, mul_pkg::OP_GORC:
            is_perm = 1'b1;
         mul_pkg::OP_CRC32_B, mul_pkg::OP_CRC32C_B:
            is_crc = 1'b1;
         mul_pkg::OP_CRC32_H, mul_pkg::OP_CRC32C_H:
         begin
            is_crc          = 1'b1;
            crc_cfg_o.width = mul_pkg::CRC_HALF;
         end
         mul_pkg::OP_CRC32_W, mul_pkg::OP_CRC32C_W:
         begin
            is_crc          = 1'b1;
            crc_cfg_o.width = mul_pkg::CRC_WORD;
         end
         default:
            low_d = 1'b0;
      endcase
      crc_cfg_o.castagnoli = mul_pkt_i.op inside
         {mul_pkg::OP_CRC32C_B, mul_pkg::OP_CRC32C_H, mul_pkg::OP_CRC32C_W};
   end

   assign or_combine_o = (mul_pkt_i.op == mul_pkg::OP_GORC);

   assign mul_dec_o.enable   = mul_pkt_i.valid;
   assign mul_dec_o.rs1_sign = rs1_sign;
   assign mul_dec_o.rs2_sign = rs2_sign;

   // A disabled family falls back to the product high word
   assign sel_clmul  = EN_CLMUL & is_clmul;
   assign sel_clmulh = EN_CLMUL & is_clmulh;
   assign sel_clmulr = EN_CLMUL & is_clmulr;
   assign sel_perm   = EN_PERM & is_perm;
   assign sel_crc    = EN_CRC & is_crc;

   assign bit_sel_d = sel_clmul | sel_clmulh | sel_clmulr | sel_perm | sel_crc;

   // One-hot AND-OR of the unit results
   assign bit_d = ({mul_pkg::XLEN{sel_clmul}}  & clmul_i[mul_pkg::XLEN-1:0])
                | ({mul_pkg::XLEN{sel_clmulh}} & {1'b0, clmul_i[mul_pkg::CLMUL_W-1:mul_pkg::XLEN]})
                | ({mul_pkg::XLEN{sel_clmulr}} & clmul_i[mul_pkg::CLMUL_W-1:mul_pkg::XLEN-1])
                | ({mul_pkg::XLEN{sel_perm}}   & perm_i)
                | ({mul_pkg::XLEN{sel_crc}}    & crc_i);

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         low_q     <= 1'b0;
         bit_sel_q <= 1'b0;
         bit_q     <= '0;
      end
      else if (mul_pkt_i.valid)
      begin
         low_q     <= low_d;
         bit_sel_q <= bit_sel_d;
         bit_q     <= bit_d;
      end
   end

   // Product bits above 63 only carry sign
   assign result_o = bit_sel_q ? bit_q :
                     low_q     ? prod_i[mul_pkg::XLEN-1:0] :
                                 prod_i[2*mul_pkg::XLEN-1:mul_pkg::XLEN];

endmodule

/* source/mul_pkg.sv */
// Multiply stage package with widths, operation codes, control structs and CRC polynomials
package mul_pkg;

   // Operand and result width
   localparam int XLEN = 32;

   // Two 33-bit operands after sign extension
   localparam int PROD_W = 2 * (XLEN + 1);

   // Carry-less product of two XLEN-bit words
   localparam int CLMUL_W = 2 * XLEN - 1;

   // Operation code seen by the multiply stage
   typedef enum logic [3:0] {
      OP_MUL      = 4'd0,
      OP_MULH     = 4'd1,
      OP_MULHSU   = 4'd2,
      OP_MULHU    = 4'd3,
      OP_CLMUL    = 4'd4,
      OP_CLMULH   = 4'd5,
      OP_CLMULR   = 4'd6,
      OP_GREV     = 4'd7,
      OP_GORC     = 4'd8,
      OP_CRC32_B  = 4'd9,
      OP_CRC32_H  = 4'd10,
      OP_CRC32_W  = 4'd11,
      OP_CRC32C_B = 4'd12,
      OP_CRC32C_H = 4'd13,
      OP_CRC32C_W = 4'd14
   } mul_op_e;

   // Operation packet from the decode stage
   typedef struct packed {
      logic    valid;
      mul_op_e op;
   } mul_pkt_t;

   // Controls for the multiplier array
   typedef struct packed {
      logic enable;
      logic rs1_sign;
      logic rs2_sign;
   } mul_dec_t;

   // Number of input bits folded into one CRC step
   typedef enum logic [1:0] {
      CRC_BYTE = 2'd0,
      CRC_HALF = 2'd1,
      CRC_WORD = 2'd2
   } crc_width_e;

   typedef struct packed {
      logic       castagnoli;
      crc_width_e width;
   } crc_cfg_t;

   // Bit-reversed forms of 0x04C11DB7 and 0x1EDC6F41
   localparam logic [XLEN-1:0] CRC32_POLY_REV  = 32'hEDB8_8320;
   localparam logic [XLEN-1:0] CRC32C_POLY_REV = 32'h82F6_3B78;

endpackage
